// ==== rtl/dhcp_defs.svh ====
`ifndef DHCP_DEFS_SVH
`define DHCP_DEFS_SVH

// frame layout
`define DHCP_HDR_LEN         236
`define DHCP_OPT_START       240
`define DHCP_COOKIE          32'h63825363

// 240 + 53/1/t + 50/4/ip + 61/7/hw/mac + end
`define DHCP_DISCOVER_LEN    259
// discover plus 54/4/server id
`define DHCP_REQUEST_LEN     265

// client identity
`define DHCP_XID             32'h3c5a_9e17
`define DHCP_MAC_ADDR        48'h02_1a_4b_00_c3_7e
`define DHCP_FLAGS_BROADCAST 16'h8000

// timing
`define DHCP_TIMEOUT_CYCLES  600 // per reply wait
`define DHCP_RETRIES         2   // extra attempts after the first

`endif

// ==== rtl/dhcp_msg_pkg.sv ====
`default_nettype none

package dhcp_msg_pkg;

  typedef logic [3:0][7:0] ipv4_t;     // byte 3 goes first on the wire
  typedef logic [5:0][7:0] mac_addr_t;

  typedef enum logic [7:0] {
    boot_request = 8'd1,
    boot_reply   = 8'd2
  } dhcp_op_e;

  typedef enum logic [7:0] {
    discover = 8'd1,
    offer    = 8'd2,
    request  = 8'd3,
    ack      = 8'd5
  } dhcp_msg_type_e;

  typedef enum logic [7:0] {
    opt_pad          = 8'd0,
    opt_subnet_mask  = 8'd1,
    opt_router       = 8'd3,
    opt_requested_ip = 8'd50,
    opt_msg_type     = 8'd53,
    opt_server_id    = 8'd54,
    opt_client_id    = 8'd61,
    opt_end          = 8'd255
  } dhcp_opt_code_e;

  // fields of a received reply
  typedef struct packed {
    dhcp_op_e       op;
    logic [31:0]    xid;
    ipv4_t          yiaddr;
    ipv4_t          siaddr;
    dhcp_msg_type_e msg_type;
    ipv4_t          subnet_mask;
    logic           subnet_pres;
    ipv4_t          router;
    logic           router_pres;
  } dhcp_rx_msg_t;

  // what the client wants sent
  typedef struct packed {
    dhcp_msg_type_e msg_type;
    ipv4_t          requested_ip;
    ipv4_t          server_id; // REQUEST only
  } dhcp_tx_req_t;

endpackage

`default_nettype wire

// ==== rtl/dhcp_ctl_pkg.sv ====
`default_nettype none

package dhcp_ctl_pkg;

  typedef enum logic [2:0] {
    idle_s,
    discover_s,
    offer_s,
    request_s,
    ack_s,
    done_s
  } client_state_e;

  // option walk position
  typedef enum logic [1:0] {
    kind,
    len,
    data
  } opt_field_e;

  typedef struct packed {
    dhcp_msg_pkg::ipv4_t assigned_ip;
    dhcp_msg_pkg::ipv4_t router_ip;
    logic                router_val;
    dhcp_msg_pkg::ipv4_t subnet_mask;
    logic                subnet_val;
  } dhcp_lease_t;

endpackage

`default_nettype wire

// ==== rtl/dhcp_rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dhcp_defs.svh"

module dhcp_rx_parser (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       rx_valid,
  input  logic [7:0]                 rx_data,
  input  logic                       rx_last,
  output logic                       rx_ready,
  output logic                       msg_valid,
  input  logic                       msg_ready,
  output dhcp_msg_pkg::dhcp_rx_msg_t msg
);

  logic [7:0]                   byte_cnt; // parks at the first option byte
  logic                         cookie_ok;
  logic                         end_seen;
  dhcp_ctl_pkg::opt_field_e     opt_field;
  dhcp_msg_pkg::dhcp_opt_code_e opt_code;
  logic [7:0]                   opt_len;
  logic [7:0]                   opt_cnt;
  logic [3:0][7:0]              cookie_w;
  logic                         rx_fire;
  logic                         in_opts;
  logic                         end_now;

  assign cookie_w = `DHCP_COOKIE;
  assign rx_ready = !msg_valid; // stall while a message waits
  assign rx_fire  = rx_valid && rx_ready;
  assign in_opts  = (byte_cnt == 8'(`DHCP_OPT_START)) && !end_seen;
  assign end_now  = in_opts && (opt_field == dhcp_ctl_pkg::kind) &&
                    (rx_data == dhcp_msg_pkg::opt_end);

  //////////////////////////////////////////////////
  // frame control

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt  <= '0;
      cookie_ok <= 1'b1;
      end_seen  <= 1'b0;
      opt_field <= dhcp_ctl_pkg::kind;
      msg_valid <= 1'b0;
    end else begin
      if (msg_valid && msg_ready) msg_valid <= 1'b0;
      if (rx_fire) begin
        if (byte_cnt != 8'(`DHCP_OPT_START)) byte_cnt <= byte_cnt + 8'd1;
        if (byte_cnt >= `DHCP_HDR_LEN && byte_cnt < `DHCP_OPT_START &&
            rx_data != cookie_w[`DHCP_OPT_START - 1 - byte_cnt]) begin
          cookie_ok <= 1'b0;
        end
        if (end_now) end_seen <= 1'b1;
        if (in_opts) begin
          case (opt_field)
            dhcp_ctl_pkg::kind: begin
              if (rx_data != dhcp_msg_pkg::opt_pad && rx_data != dhcp_msg_pkg::opt_end)
                opt_field <= dhcp_ctl_pkg::len;
            end
            dhcp_ctl_pkg::len:
              opt_field <= (rx_data == 8'd0) ? dhcp_ctl_pkg::kind : dhcp_ctl_pkg::data;
            default: begin
              if (opt_cnt == opt_len - 8'd1) opt_field <= dhcp_ctl_pkg::kind;
            end
          endcase
        end
        if (rx_last) begin
          // needs good cookie and end option by now
          msg_valid <= cookie_ok && (end_seen || end_now);
          byte_cnt  <= '0;
          cookie_ok <= 1'b1;
          end_seen  <= 1'b0;
          opt_field <= dhcp_ctl_pkg::kind;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // field capture

  always_ff @(posedge clk) begin
    if (rx_fire) begin
      case (byte_cnt) inside
        8'd0: begin
          msg.op          <= dhcp_msg_pkg::dhcp_op_e'(rx_data);
          msg.msg_type    <= dhcp_msg_pkg::dhcp_msg_type_e'(8'd0); // no type yet
          msg.subnet_pres <= 1'b0;
          msg.router_pres <= 1'b0;
        end
        [8'd4:8'd7]:   msg.xid    <= {msg.xid[23:0], rx_data};
        [8'd16:8'd19]: msg.yiaddr <= {msg.yiaddr[2:0], rx_data};
        [8'd20:8'd23]: msg.siaddr <= {msg.siaddr[2:0], rx_data};
        default: ;
      endcase
      if (in_opts) begin
        case (opt_field)
          dhcp_ctl_pkg::kind: begin
            opt_code <= dhcp_msg_pkg::dhcp_opt_code_e'(rx_data);
            opt_cnt  <= '0;
            if (rx_data == dhcp_msg_pkg::opt_subnet_mask) msg.subnet_pres <= 1'b1;
            if (rx_data == dhcp_msg_pkg::opt_router) msg.router_pres <= 1'b1;
          end
          dhcp_ctl_pkg::len: opt_len <= rx_data;
          default: begin
            opt_cnt <= opt_cnt + 8'd1;
            case (opt_code)
              dhcp_msg_pkg::opt_msg_type:
                msg.msg_type <= dhcp_msg_pkg::dhcp_msg_type_e'(rx_data);
              dhcp_msg_pkg::opt_subnet_mask:
                msg.subnet_mask <= {msg.subnet_mask[2:0], rx_data};
              dhcp_msg_pkg::opt_router: begin
                if (opt_cnt < 8'd4) msg.router <= {msg.router[2:0], rx_data}; // first only
              end
              default: ; // skipped by length
            endcase
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dhcp_client_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dhcp_defs.svh"

module dhcp_client_fsm (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       start,
  input  logic                       msg_valid,
  output logic                       msg_ready,
  input  dhcp_msg_pkg::dhcp_rx_msg_t msg,
  output logic                       req_valid,
  input  logic                       req_ready,
  output dhcp_msg_pkg::dhcp_tx_req_t req,
  output logic                       busy,
  output logic                       success,
  output logic                       fail,
  output dhcp_ctl_pkg::dhcp_lease_t  lease
);

  typedef logic [$clog2(`DHCP_TIMEOUT_CYCLES)-1:0] tmr_t;
  typedef logic [$clog2(`DHCP_RETRIES + 2)-1:0]    att_t;

  dhcp_ctl_pkg::client_state_e state;
  tmr_t                        timer;
  att_t                        attempt;
  dhcp_msg_pkg::ipv4_t         offered_ip;
  dhcp_msg_pkg::ipv4_t         server_ip;
  logic                        reply_ok;
  logic                        got_offer;
  logic                        got_ack;
  logic                        waiting;
  logic                        expire;

  // sending states hold off replies until the request is taken
  assign msg_ready = (state != dhcp_ctl_pkg::discover_s) &&
                     (state != dhcp_ctl_pkg::request_s);
  assign req_valid = !msg_ready;

  assign reply_ok  = msg_valid && (msg.op == dhcp_msg_pkg::boot_reply) &&
                     (msg.xid == `DHCP_XID);
  assign got_offer = reply_ok && (state == dhcp_ctl_pkg::offer_s) &&
                     (msg.msg_type == dhcp_msg_pkg::offer);
  assign got_ack   = reply_ok && (state == dhcp_ctl_pkg::ack_s) &&
                     (msg.msg_type == dhcp_msg_pkg::ack);
  assign waiting   = (state == dhcp_ctl_pkg::offer_s) || (state == dhcp_ctl_pkg::ack_s);
  assign expire    = waiting && (timer == tmr_t'(`DHCP_TIMEOUT_CYCLES - 1)) &&
                     !got_offer && !got_ack; // a reply wins a tie

  always_comb begin
    req.msg_type     = dhcp_msg_pkg::discover;
    req.requested_ip = '0; // no preferred address
    req.server_id    = '0;
    if (state == dhcp_ctl_pkg::request_s) begin
      req.msg_type     = dhcp_msg_pkg::request;
      req.requested_ip = offered_ip;
      req.server_id    = server_ip;
    end
  end

  //////////////////////////////////////////////////
  // DORA sequencing

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state            <= dhcp_ctl_pkg::idle_s;
      timer            <= '0;
      attempt          <= '0;
      busy             <= 1'b0;
      success          <= 1'b0;
      fail             <= 1'b0;
      lease.router_val <= 1'b0;
      lease.subnet_val <= 1'b0;
    end else begin
      if (waiting) timer <= timer + tmr_t'(1);
      case (state)
        dhcp_ctl_pkg::idle_s, dhcp_ctl_pkg::done_s: begin
          if (start) begin
            state            <= dhcp_ctl_pkg::discover_s;
            attempt          <= '0;
            busy             <= 1'b1;
            success          <= 1'b0;
            fail             <= 1'b0;
            lease.router_val <= 1'b0;
            lease.subnet_val <= 1'b0;
          end
        end
        dhcp_ctl_pkg::discover_s: begin
          if (req_ready) begin
            state <= dhcp_ctl_pkg::offer_s;
            timer <= '0;
          end
        end
        dhcp_ctl_pkg::offer_s: begin
          if (got_offer) begin
            state      <= dhcp_ctl_pkg::request_s;
            offered_ip <= msg.yiaddr;
            server_ip  <= msg.siaddr;
          end
        end
        dhcp_ctl_pkg::request_s: begin
          if (req_ready) begin
            state <= dhcp_ctl_pkg::ack_s;
            timer <= '0;
          end
        end
        dhcp_ctl_pkg::ack_s: begin
          if (got_ack) begin
            state             <= dhcp_ctl_pkg::done_s;
            busy              <= 1'b0;
            success           <= 1'b1;
            lease.assigned_ip <= msg.yiaddr;
            lease.router_ip   <= msg.router;
            lease.router_val  <= msg.router_pres;
            lease.subnet_mask <= msg.subnet_mask;
            lease.subnet_val  <= msg.subnet_pres;
          end
        end
        default: state <= dhcp_ctl_pkg::idle_s;
      endcase

      // no reply in time, start over or give up
      if (expire) begin
        if (attempt == att_t'(`DHCP_RETRIES)) begin
          state <= dhcp_ctl_pkg::done_s;
          busy  <= 1'b0;
          fail  <= 1'b1;
        end else begin
          state   <= dhcp_ctl_pkg::discover_s;
          attempt <= attempt + att_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dhcp_tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dhcp_defs.svh"

module dhcp_tx_serializer (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  dhcp_msg_pkg::dhcp_tx_req_t req,
  output logic                       tx_valid,
  output logic [7:0]                 tx_data,
  output logic                       tx_last,
  input  logic                       tx_ready
);

  dhcp_msg_pkg::dhcp_tx_req_t req_q;
  logic [8:0]                 byte_cnt;
  logic [8:0]                 last_idx;
  logic [8:0]                 cid_base; // offset of the client id option
  logic [8:0]                 cid_rel;
  logic [3:0][7:0]            xid_w;
  logic [3:0][7:0]            cookie_w;
  logic [1:0][7:0]            flags_w;
  dhcp_msg_pkg::mac_addr_t    mac;

  assign xid_w    = `DHCP_XID;
  assign cookie_w = `DHCP_COOKIE;
  assign flags_w  = `DHCP_FLAGS_BROADCAST;
  assign mac      = `DHCP_MAC_ADDR;

  assign last_idx  = (req_q.msg_type == dhcp_msg_pkg::request) ?
                     9'(`DHCP_REQUEST_LEN - 1) : 9'(`DHCP_DISCOVER_LEN - 1);
  assign cid_base  = last_idx - 9'd9;
  assign cid_rel   = byte_cnt - cid_base;
  assign req_ready = !tx_valid;
  assign tx_last   = tx_valid && (byte_cnt == last_idx);

  //////////////////////////////////////////////////
  // byte from offset

  always_comb begin
    tx_data = 8'h00; // zero addresses, sname, file
    if (byte_cnt < 9'(`DHCP_OPT_START)) begin
      case (byte_cnt) inside
        9'd0:          tx_data = dhcp_msg_pkg::boot_request;
        9'd1:          tx_data = 8'd1; // htype ethernet
        9'd2:          tx_data = 8'd6; // hlen
        [9'd4:9'd7]:   tx_data = xid_w[9'd7 - byte_cnt];
        [9'd10:9'd11]: tx_data = flags_w[9'd11 - byte_cnt];
        [9'd28:9'd33]: tx_data = mac[9'd33 - byte_cnt]; // chaddr, rest zero
        [9'(`DHCP_HDR_LEN):9'(`DHCP_OPT_START - 1)]:
          tx_data = cookie_w[9'(`DHCP_OPT_START - 1) - byte_cnt];
        default: ;
      endcase
    end else if (byte_cnt < cid_base) begin
      case (byte_cnt) inside
        9'd240:          tx_data = dhcp_msg_pkg::opt_msg_type;
        9'd241:          tx_data = 8'd1;
        9'd242:          tx_data = req_q.msg_type;
        9'd243:          tx_data = dhcp_msg_pkg::opt_requested_ip;
        9'd244:          tx_data = 8'd4;
        [9'd245:9'd248]: tx_data = req_q.requested_ip[9'd248 - byte_cnt];
        9'd249:          tx_data = dhcp_msg_pkg::opt_server_id; // request only
        9'd250:          tx_data = 8'd4;
        [9'd251:9'd254]: tx_data = req_q.server_id[9'd254 - byte_cnt];
        default: ;
      endcase
    end else begin
      case (cid_rel)
        9'd0:    tx_data = dhcp_msg_pkg::opt_client_id;
        9'd1:    tx_data = 8'd7;
        9'd2:    tx_data = 8'd1; // hw type then MAC
        9'd9:    tx_data = dhcp_msg_pkg::opt_end;
        default: tx_data = mac[9'd8 - cid_rel];
      endcase
    end
  end

  //////////////////////////////////////////////////
  // frame sequencing

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_valid <= 1'b0;
      byte_cnt <= '0;
    end else if (!tx_valid) begin
      if (req_valid) begin
        tx_valid <= 1'b1;
        byte_cnt <= '0;
      end
    end else if (tx_ready) begin
      byte_cnt <= byte_cnt + 9'd1;
      if (tx_last) tx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) req_q <= req;
  end

endmodule

`default_nettype wire

// ==== rtl/dhcp_client_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dhcp_client_top (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      rx_valid,
  input  logic [7:0]                rx_data,
  input  logic                      rx_last,
  output logic                      rx_ready,
  output logic                      tx_valid,
  output logic [7:0]                tx_data,
  output logic                      tx_last,
  input  logic                      tx_ready,
  input  logic                      start,
  output logic                      busy,
  output logic                      success,
  output logic                      fail,
  output dhcp_ctl_pkg::dhcp_lease_t lease
);

  logic                       msg_valid;
  logic                       msg_ready;
  dhcp_msg_pkg::dhcp_rx_msg_t msg;
  logic                       req_valid;
  logic                       req_ready;
  dhcp_msg_pkg::dhcp_tx_req_t req;

  // replies in
  dhcp_rx_parser i_rx_parser (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .msg_valid (msg_valid),
    .msg_ready (msg_ready),
    .msg       (msg)
  );

  dhcp_client_fsm i_client_fsm (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .start     (start),
    .msg_valid (msg_valid),
    .msg_ready (msg_ready),
    .msg       (msg),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .busy      (busy),
    .success   (success),
    .fail      (fail),
    .lease     (lease)
  );

  // requests out
  dhcp_tx_serializer i_tx_serializer (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_last   (tx_last),
    .tx_ready  (tx_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/dhcp_client_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module dhcp_client_sva (
  input logic                     clk,
  input logic                     fsm_rst,
  input logic                     rx_valid,
  input logic                     rx_last,
  input logic                     rx_ready,
  input logic                     tx_valid,
  input logic [7:0]               tx_data,
  input logic                     tx_last,
  input logic                     tx_ready,
  input logic                     busy,
  input logic                     success,
  input logic                     fail,
  input dhcp_ctl_pkg::opt_field_e opt_field
);

  int unsigned err_cnt = 0; // watched by the testbench

  a_tx_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
  else begin
    err_cnt++;
    $error("tx byte changed while stalled");
  end

  // outputs idle right after any reset edge
  a_reset_idle: assert property (@(posedge clk)
    fsm_rst |=> !tx_valid && !success && !fail && !busy && rx_ready)
  else begin
    err_cnt++;
    $error("outputs not idle after reset");
  end

  a_one_result: assert property (@(posedge clk) disable iff (fsm_rst) !(success && fail))
  else begin
    err_cnt++;
    $error("success and fail high together");
  end

  // well formed frames end on an option boundary
  a_opt_field: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_valid && rx_ready && rx_last |-> opt_field == dhcp_ctl_pkg::kind)
  else begin
    err_cnt++;
    $error("parser option walk not at an option boundary at frame end");
  end

endmodule

bind dhcp_client_top dhcp_client_sva i_sva (
  .clk       (clk),
  .fsm_rst   (fsm_rst),
  .rx_valid  (rx_valid),
  .rx_last   (rx_last),
  .rx_ready  (rx_ready),
  .tx_valid  (tx_valid),
  .tx_data   (tx_data),
  .tx_last   (tx_last),
  .tx_ready  (tx_ready),
  .busy      (busy),
  .success   (success),
  .fail      (fail),
  .opt_field (i_rx_parser.opt_field)
);

`default_nettype wire

// ==== testbench/dhcp_client_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dhcp_defs.svh"

module dhcp_client_tb;

  localparam int watchdog_cycles =
    4 * (`DHCP_RETRIES + 1) * (`DHCP_TIMEOUT_CYCLES + 300);
  localparam logic [31:0] stale_ip  = 32'hc0a8_0109; // only in the bad offer
  localparam logic [31:0] offer_ip  = 32'hc0a8_0142;
  localparam logic [31:0] server_ip = 32'hc0a8_0101;
  localparam logic [31:0] router_ip = 32'hc0a8_01fe;
  localparam logic [31:0] mask_ip   = 32'hffff_ff00;

  logic                      clk;
  logic                      fsm_rst;
  logic                      rx_valid;
  logic [7:0]                rx_data;
  logic                      rx_last;
  logic                      rx_ready;
  logic                      tx_valid;
  logic [7:0]                tx_data;
  logic                      tx_last;
  logic                      tx_ready;
  logic                      start;
  logic                      busy;
  logic                      success;
  logic                      fail;
  dhcp_ctl_pkg::dhcp_lease_t lease;

  integer     seed = 1225;
  logic [7:0] rx_bytes[$];   // reply under construction
  logic [7:0] cur_frame[$];
  logic [7:0] last_frame[$];
  int         frame_cnt = 0;
  int         disc_cnt = 0;
  int         base_cnt;

  dhcp_client_top i_dut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_last  (rx_last),
    .rx_ready (rx_ready),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_last  (tx_last),
    .tx_ready (tx_ready),
    .start    (start),
    .busy     (busy),
    .success  (success),
    .fail     (fail),
    .lease    (lease)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    tx_ready = 1'b0;
    forever begin
      @(negedge clk);
      tx_ready = ($random(seed) & 3) != 0; // ready about 3 of 4 cycles
    end
  end

  //////////////////////////////////////////////////
  // model server, transmit side

  always @(posedge clk) begin
    if (!fsm_rst && tx_valid && tx_ready) begin
      cur_frame.push_back(tx_data);
      if (tx_last) begin
        last_frame = cur_frame;
        if (cur_frame.size() == `DHCP_DISCOVER_LEN && cur_frame[242] == 8'd1) disc_cnt++;
        frame_cnt++;
        cur_frame.delete();
      end
    end
  end

  always @(negedge clk) check_that(i_dut.i_sva.err_cnt == 0, "a bound assertion failed");

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("Timeout: run did not finish within %0d cycles", watchdog_cycles));
  end

  //////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_that(input bit ok, input string what);
    assert (ok) else abort_run($sformatf("Error at %0d ns: %s", $time, what));
  endtask

  task automatic check_byte(input int idx, input logic [7:0] exp, input string what);
    check_that(last_frame[idx] === exp, $sformatf("%s byte %0d is %h, expected %h",
               what, idx, last_frame[idx], exp));
  endtask

  task automatic check_word(input int idx, input logic [31:0] exp, input string what);
    int i;
    for (i = 0; i < 4; i++) check_byte(idx + i, exp[31 - 8 * i -: 8], what);
  endtask

  task automatic wait_frames(input int target, input int max_cycles, input string what);
    int n;
    n = 0;
    while (frame_cnt < target && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    check_that(frame_cnt >= target, $sformatf("no %s frame in %0d cycles", what, max_cycles));
  endtask

  task automatic wait_tx_start(input int max_cycles, input string what);
    int n;
    n = 0;
    while (!tx_valid && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    check_that(tx_valid, $sformatf("%s did not start in %0d cycles", what, max_cycles));
  endtask

  task automatic wait_result(input bit want_fail, input int max_cycles);
    int n;
    n = 0;
    while (!(want_fail ? fail : success) && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    check_that(want_fail ? fail : success, want_fail ? "no fail flag" : "no success flag");
  endtask

  // bootp reply header plus cookie
  task automatic build_header(input logic [31:0] xid, input logic [31:0] yiaddr,
                              input logic [31:0] siaddr);
    int i;
    logic [31:0] cookie;
    logic [47:0] mac;
    cookie = `DHCP_COOKIE;
    mac    = `DHCP_MAC_ADDR;
    rx_bytes.delete();
    for (i = 0; i < `DHCP_OPT_START; i++) rx_bytes.push_back(8'h00);
    rx_bytes[0] = 8'd2;
    rx_bytes[1] = 8'd1;
    rx_bytes[2] = 8'd6;
    for (i = 0; i < 4; i++) begin
      rx_bytes[4 + i]   = xid[31 - 8 * i -: 8];
      rx_bytes[16 + i]  = yiaddr[31 - 8 * i -: 8];
      rx_bytes[20 + i]  = siaddr[31 - 8 * i -: 8];
      rx_bytes[236 + i] = cookie[31 - 8 * i -: 8];
    end
    for (i = 0; i < 6; i++) rx_bytes[28 + i] = mac[47 - 8 * i -: 8];
  endtask

  task automatic put_opt4(input logic [7:0] code, input logic [31:0] value);
    int i;
    rx_bytes.push_back(code);
    rx_bytes.push_back(8'd4);
    for (i = 0; i < 4; i++) rx_bytes.push_back(value[31 - 8 * i -: 8]);
  endtask

  task automatic build_offer(input logic [31:0] xid, input logic [31:0] yiaddr);
    build_header(xid, yiaddr, server_ip);
    rx_bytes.push_back(8'd53);
    rx_bytes.push_back(8'd1);
    rx_bytes.push_back(8'd2);
    rx_bytes.push_back(8'd255);
  endtask

  task automatic build_ack();
    build_header(`DHCP_XID, offer_ip, server_ip);
    rx_bytes.push_back(8'd53);
    rx_bytes.push_back(8'd1);
    rx_bytes.push_back(8'd5);
    rx_bytes.push_back(8'd0); // pads
    rx_bytes.push_back(8'd0);
    put_opt4(8'd1, mask_ip);
    put_opt4(8'd3, router_ip);
    rx_bytes.push_back(8'd0);
    put_opt4(8'd51, 32'h0000_0e10); // lease time, not parsed
    rx_bytes.push_back(8'd255);
  endtask

  // one byte per accepted beat, driven on the falling edge
  task automatic send_frame();
    int i;
    for (i = 0; i < rx_bytes.size(); i++) begin
      rx_valid = 1'b1;
      rx_data  = rx_bytes[i];
      rx_last  = (i == rx_bytes.size() - 1);
      do @(posedge clk); while (!rx_ready);
      @(negedge clk);
    end
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    fsm_rst  = 1'b1;
    start    = 1'b0;
    rx_valid = 1'b0;
    rx_data  = 8'h00;
    rx_last  = 1'b0;
    repeat (5) @(negedge clk);
    fsm_rst = 1'b0;
    @(negedge clk);

    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_that(busy, "busy not raised after start");
    wait_tx_start(3, "DISCOVER");

    // offers go out while the DISCOVER is still streaming, timer runs from its start
    fork
      begin
        wait_frames(1, 2000, "DISCOVER");
        check_that(last_frame.size() == `DHCP_DISCOVER_LEN,
                   $sformatf("DISCOVER has %0d bytes", last_frame.size()));
        check_byte(0, 8'd1, "DISCOVER op");
        check_word(4, `DHCP_XID, "DISCOVER xid");
        check_word(236, `DHCP_COOKIE, "DISCOVER cookie");
        check_byte(240, 8'd53, "DISCOVER option");
        check_byte(241, 8'd1, "DISCOVER option");
        check_byte(242, 8'd1, "DISCOVER type");
        check_byte(`DHCP_DISCOVER_LEN - 1, 8'd255, "DISCOVER end");
      end
      begin
        build_offer(`DHCP_XID ^ 32'h1, stale_ip);
        send_frame();
        build_offer(`DHCP_XID, offer_ip);
        send_frame();
      end
    join

    wait_tx_start(50, "REQUEST");
    fork
      begin
        wait_frames(2, 2000, "REQUEST");
        check_that(last_frame.size() == `DHCP_REQUEST_LEN,
                   $sformatf("REQUEST has %0d bytes", last_frame.size()));
        check_byte(242, 8'd3, "REQUEST type");
        check_byte(243, 8'd50, "REQUEST option");
        check_byte(244, 8'd4, "REQUEST option");
        check_word(245, offer_ip, "requested ip");
        check_byte(249, 8'd54, "REQUEST option");
        check_byte(250, 8'd4, "REQUEST option");
        check_word(251, server_ip, "server id");
        check_byte(`DHCP_REQUEST_LEN - 1, 8'd255, "REQUEST end");
      end
      begin
        build_ack();
        send_frame();
        wait_result(1'b0, `DHCP_TIMEOUT_CYCLES);
        check_that(!busy, "busy still high after ACK");
        check_that(lease.assigned_ip == offer_ip, "wrong assigned ip");
        check_that(lease.router_ip == router_ip, "wrong router ip");
        check_that(lease.subnet_mask == mask_ip, "wrong subnet mask");
        check_that(lease.router_val && lease.subnet_val, "lease option flags low");
      end
    join

    // no replies this time
    base_cnt = disc_cnt;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_result(1'b1, (`DHCP_RETRIES + 1) * (`DHCP_TIMEOUT_CYCLES + 300));
    check_that(disc_cnt - base_cnt == `DHCP_RETRIES + 1,
               $sformatf("%0d DISCOVER frames before fail", disc_cnt - base_cnt));
    check_that(!success, "success high after failed run");
    check_that(!busy, "busy high after fail");
    repeat (10) @(negedge clk);

    if (i_dut.i_sva.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("a bound assertion failed near the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/dhcp_msg_pkg.sv
rtl/dhcp_ctl_pkg.sv
rtl/dhcp_rx_parser.sv
rtl/dhcp_client_fsm.sv
rtl/dhcp_tx_serializer.sv
rtl/dhcp_client_top.sv
testbench/dhcp_client_sva.sv
testbench/dhcp_client_tb.sv
